// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := pktgen_tb
FLIST     := pktgen.f
RUNARGS   := +verilator+error+limit+1000

SRCS := $(shell cat $(FLIST))
BIN  := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST)

run: $(BIN)
	@out="$$(./$(BIN) $(RUNARGS))"; echo "$$out"; \
	echo "$$out" | grep -qx "SIMULATION PASSED"

clean:
	rm -rf obj_dir

// ==== bench/pktgen_sva.sv ====
/* frame generator reference checks */
module pktgen_sva
	import pktgen_pkg::*;
	#(
	parameter int GAP_CYCLES = 16,
	parameter int MAX_LEN    = 500
	) (
	input logic       clk,
	input logic       i_rst_n,
	input logic       i_start,
	input len_mode_t  i_len_mode,
	input pat_mode_t  i_pat_mode,
	input len_t       i_base_len,
	input len_t       i_len_step,
	input logic [7:0] i_fix_byte,
	input cnt_t       i_num_frames,
	input logic       o_done,
	input logic       o_mem_wr,
	input addr_t      o_mem_addr,
	input word_t      o_mem_data,
	input logic       o_mem_sop,
	input logic       o_mem_eop,
	input addr_t      o_last_addr
);

	timeunit 1ns;
	timeprecision 1ps;

	// read by the testbench for the closing report
	int fails = 0;

	logic        start_q;
	logic        start_rise;
	addr_t       exp_addr;
	len_t        exp_len;
	len_t        widx;
	len_t        cur_idx;
	cnt_t        fr_cnt;
	logic        last_frame;
	logic        in_frame;
	logic        after_eop;
	int          idle_cnt;
	word_t       crc;
	logic [11:0] len_sum;
	len_t        len_nxt;
	logic        fix_mode;
	logic        data_wr;

	// --------------------------------------------------
	// reference crc-32, byte at a time, low byte first
	function automatic word_t crc_ref(input word_t c_in, input word_t w);
		word_t      c;
		logic [7:0] b;
		c = c_in;
		for (int n = 0; n < 4; n++) begin
			b = w[8*n +: 8];
			c = c ^ word_t'(b);
			for (int k = 0; k < 8; k++) begin
				c = c[0] ? ((c >> 1) ^ CRC_POLY) : (c >> 1);
			end
		end
		return c;
	endfunction

	assign start_rise = i_start && !start_q;
	assign data_wr    = o_mem_wr && !o_mem_eop;
	// index of the word being written now
	assign cur_idx    = o_mem_sop ? '0 : widx;
	assign last_frame = (fr_cnt + cnt_t'(1) == i_num_frames);
	assign fix_mode   = (i_pat_mode != PAT_INC) && (i_pat_mode != PAT_LFSR);

	// next expected length, saturating in incrementing mode
	assign len_sum = {1'b0, exp_len} + {1'b0, i_len_step};
	assign len_nxt = !i_len_mode ? exp_len :
		(len_sum > 12'(MAX_LEN)) ? len_t'(MAX_LEN) : len_sum[10:0];

	// --------------------------------------------------
	// reference state
	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			start_q   <= 1'b0;
			exp_addr  <= '0;
			exp_len   <= '0;
			widx      <= '0;
			fr_cnt    <= '0;
			in_frame  <= 1'b0;
			after_eop <= 1'b0;
			idle_cnt  <= 0;
			crc       <= CRC_INIT;
		end else begin
			start_q <= i_start;
			// address count restarts once a run is done
			if (o_done) begin
				exp_addr <= '0;
			end else if (o_mem_wr) begin
				exp_addr <= exp_addr + addr_t'(1);
			end
			if (start_rise) begin
				exp_len   <= i_base_len;
				fr_cnt    <= '0;
				after_eop <= 1'b0;
			end else if (o_mem_eop) begin
				exp_len   <= len_nxt;
				fr_cnt    <= fr_cnt + cnt_t'(1);
				after_eop <= 1'b1;
			end
			if (data_wr) begin
				widx <= cur_idx + len_t'(1);
				crc  <= crc_ref(o_mem_sop ? CRC_INIT : crc, o_mem_data);
			end
			if (o_mem_eop) begin
				in_frame <= 1'b0;
			end else if (o_mem_wr) begin
				in_frame <= 1'b1;
			end
			// write-free cycles since the last write
			idle_cnt <= o_mem_wr ? 0 : idle_cnt + 1;
		end
	end

	// --------------------------------------------------
	// handshake
	a_done_rise: assert property (@(posedge clk) disable iff (!i_rst_n)
		o_mem_eop && last_frame |=> $rose(o_done))
		else begin
			fails++;
			$error("done did not rise after the final fcs word");
		end
	a_done_cause: assert property (@(posedge clk) disable iff (!i_rst_n)
		$rose(o_done) |-> $past(o_mem_eop))
		else begin
			fails++;
			$error("done rose without a preceding fcs word");
		end
	a_done_hold: assert property (@(posedge clk) disable iff (!i_rst_n)
		o_done && i_start |=> o_done)
		else begin
			fails++;
			$error("done fell while start was still high");
		end
	a_done_fall: assert property (@(posedge clk) disable iff (!i_rst_n)
		o_done && !i_start |=> !o_done)
		else begin
			fails++;
			$error("done stayed high after start fell");
		end
	a_quiet: assert property (@(posedge clk) disable iff (!i_rst_n)
		o_done || !i_start |-> !o_mem_wr)
		else begin
			fails++;
			$error("memory write outside a running request");
		end

	// framing and gap
	a_sop_first: assert property (@(posedge clk) disable iff (!i_rst_n)
		o_mem_wr && !in_frame |-> o_mem_sop && !o_mem_eop)
		else begin
			fails++;
			$error("frame did not open with a sop write");
		end
	a_contig: assert property (@(posedge clk) disable iff (!i_rst_n)
		data_wr |=> o_mem_wr)
		else begin
			fails++;
			$error("write stream broke inside a frame");
		end
	a_len: assert property (@(posedge clk) disable iff (!i_rst_n)
		o_mem_eop |-> o_mem_wr && widx == exp_len)
		else begin
			fails++;
			$error("FAILED frame_len got %h exp %h", widx, exp_len);
		end
	a_gap: assert property (@(posedge clk) disable iff (!i_rst_n)
		o_mem_sop && after_eop |-> idle_cnt == GAP_CYCLES)
		else begin
			fails++;
			$error("FAILED gap got %h exp %h", idle_cnt, GAP_CYCLES);
		end

	// addresses
	a_addr: assert property (@(posedge clk) disable iff (!i_rst_n)
		o_mem_wr |-> o_mem_addr == exp_addr)
		else begin
			fails++;
			$error("FAILED o_mem_addr got %h exp %h", o_mem_addr, exp_addr);
		end
	a_last: assert property (@(posedge clk) disable iff (!i_rst_n)
		$rose(o_done) |-> o_last_addr == exp_addr)
		else begin
			fails++;
			$error("FAILED o_last_addr got %h exp %h", o_last_addr, exp_addr);
		end

	// payload and fcs
	a_fix: assert property (@(posedge clk) disable iff (!i_rst_n)
		data_wr && fix_mode |-> o_mem_data == {4{i_fix_byte}})
		else begin
			fails++;
			$error("FAILED o_mem_data got %h exp %h", o_mem_data, {4{i_fix_byte}});
		end
	a_inc: assert property (@(posedge clk) disable iff (!i_rst_n)
		data_wr && i_pat_mode == PAT_INC |-> o_mem_data == word_t'(cur_idx))
		else begin
			fails++;
			$error("FAILED o_mem_data got %h exp %h", o_mem_data, word_t'(cur_idx));
		end
	a_fcs: assert property (@(posedge clk) disable iff (!i_rst_n)
		o_mem_eop |-> o_mem_data == ~crc)
		else begin
			fails++;
			$error("FAILED fcs o_mem_data got %h exp %h", o_mem_data, ~crc);
		end

endmodule

// ==== bench/pktgen_tb.sv ====
/* frame generator testbench */
module pktgen_tb
	import pktgen_pkg::*;
	;

	timeunit 1ns;
	timeprecision 1ps;

	// match the dut defaults, used for the run limit
	localparam int GAP_CYCLES = 16;
	localparam int MAX_LEN    = 500;
	// frames times (longest frame + fcs + gap) per round, plus handshake slack
	localparam int TIMEOUT = 3 * (4 + 1 + GAP_CYCLES) + 4 * (11 + 1 + GAP_CYCLES)
		+ 2 * (MAX_LEN + 1 + GAP_CYCLES) + 2 * (6 + 1 + GAP_CYCLES) + 600;

	logic       clk = 1'b0;
	logic       i_rst_n;
	logic       i_start;
	len_mode_t  i_len_mode;
	pat_mode_t  i_pat_mode;
	len_t       i_base_len;
	len_t       i_len_step;
	logic [7:0] i_fix_byte;
	cnt_t       i_num_frames;
	logic       o_done;
	logic       o_mem_wr;
	addr_t      o_mem_addr;
	word_t      o_mem_data;
	logic       o_mem_sop;
	logic       o_mem_eop;
	addr_t      o_last_addr;

	int seed   = 32'h4bbf1f7b;
	int errors = 0;
	int cycles = 0;

	always #4 clk = ~clk;

	pktgen_top u_pktgen_top (
		.clk          (clk),
		.i_rst_n      (i_rst_n),
		.i_start      (i_start),
		.i_len_mode   (i_len_mode),
		.i_pat_mode   (i_pat_mode),
		.i_base_len   (i_base_len),
		.i_len_step   (i_len_step),
		.i_fix_byte   (i_fix_byte),
		.i_num_frames (i_num_frames),
		.o_done       (o_done),
		.o_mem_wr     (o_mem_wr),
		.o_mem_addr   (o_mem_addr),
		.o_mem_data   (o_mem_data),
		.o_mem_sop    (o_mem_sop),
		.o_mem_eop    (o_mem_eop),
		.o_last_addr  (o_last_addr)
	);

	bind pktgen_top pktgen_sva #(
		.GAP_CYCLES (GAP_CYCLES),
		.MAX_LEN    (MAX_LEN)
	) u_sva (
		.clk          (clk),
		.i_rst_n      (i_rst_n),
		.i_start      (i_start),
		.i_len_mode   (i_len_mode),
		.i_pat_mode   (i_pat_mode),
		.i_base_len   (i_base_len),
		.i_len_step   (i_len_step),
		.i_fix_byte   (i_fix_byte),
		.i_num_frames (i_num_frames),
		.o_done       (o_done),
		.o_mem_wr     (o_mem_wr),
		.o_mem_addr   (o_mem_addr),
		.o_mem_data   (o_mem_data),
		.o_mem_sop    (o_mem_sop),
		.o_mem_eop    (o_mem_eop),
		.o_last_addr  (o_last_addr)
	);

	// --------------------------------------------------
	// one four-phase request, random idle time before it
	task automatic run_round(input len_mode_t lm, input pat_mode_t pm, input len_t base,
		input len_t step, input cnt_t frames);
		int gap;
		gap = 1 + int'($unsigned($random(seed)) % 32);
		repeat (gap) @(posedge clk);
		i_len_mode   <= lm;
		i_pat_mode   <= pm;
		i_base_len   <= base;
		i_len_step   <= step;
		i_num_frames <= frames;
		i_fix_byte   <= 8'($random(seed));
		i_start      <= 1'b1;
		@(negedge clk);
		while (!o_done) @(negedge clk);
		@(posedge clk);
		i_start <= 1'b0;
		@(negedge clk);
		while (o_done) @(negedge clk);
	endtask

	// run limit
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT) begin
			$display("run did not finish within %0d cycles", TIMEOUT);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	initial begin
		i_rst_n      = 1'b0;
		i_start      = 1'b0;
		i_len_mode   = 1'b0;
		i_pat_mode   = 2'd0;
		i_base_len   = '0;
		i_len_step   = '0;
		i_fix_byte   = 8'h00;
		i_num_frames = '0;
		repeat (15) @(posedge clk);
		// outputs must be quiet under reset
		@(negedge clk);
		if (o_mem_wr || o_mem_sop || o_mem_eop || o_done) begin
			errors++;
			$display("a write or done output was high during reset");
		end
		if (o_last_addr != '0) begin
			errors++;
			$display("FAILED o_last_addr got %h exp %h", o_last_addr, addr_t'(0));
		end
		@(posedge clk);
		i_rst_n <= 1'b1;

		// fixed length, fixed byte
		run_round(1'b0, 2'd0, len_t'(4), len_t'(0), cnt_t'(3));
		// growing length, word index payload
		run_round(1'b1, PAT_INC, len_t'(2), len_t'(3), cnt_t'(4));
		// length runs into the saturation limit
		run_round(1'b1, PAT_INC, len_t'(MAX_LEN - 10), len_t'(40), cnt_t'(2));
		// lfsr payload, only the fcs rule applies
		run_round(1'b0, PAT_LFSR, len_t'(6), len_t'(0), cnt_t'(2));

		repeat (4) @(posedge clk);
		$display("errors %0d, assertion failures %0d", errors, u_pktgen_top.u_sva.fails);
		if (errors == 0 && u_pktgen_top.u_sva.fails == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

// ==== design/pktgen_ctrl.sv ====
/* generator control fsm */
module pktgen_ctrl
	import pktgen_pkg::*;
	#(
	parameter int GAP_CYCLES = 16
	) (
	input  logic       clk,
	input  logic       i_rst_n,
	input  logic       i_start,
	input  logic       i_last_word,
	input  logic       i_gap_done,
	input  logic       i_all_sent,
	output gen_state_t o_state,
	output logic       o_frame_go,
	output logic       o_fcs_go,
	output logic       o_done
);

	// back-to-back frames when no gap is configured
	localparam bit HAS_GAP = (GAP_CYCLES > 0);

	gen_state_t state_nxt;
	// fcs word sits in the memory register one cycle after fcs_go
	logic       fcs_wr;

	// --------------------------------------------------
	// next state
	always_comb begin
		state_nxt  = o_state;
		o_frame_go = 1'b0;
		case (o_state)
			IDLE: if (i_start) begin
				state_nxt  = FRAME;
				o_frame_go = 1'b1;
			end
			FRAME: if (i_last_word) begin
				state_nxt = FCS;
			end
			FCS: if (i_all_sent) begin
				state_nxt = DONE;
			end else if (HAS_GAP) begin
				state_nxt = GAP;
			end else begin
				state_nxt  = FRAME;
				o_frame_go = 1'b1;
			end
			GAP: if (i_gap_done) begin
				state_nxt  = FRAME;
				o_frame_go = 1'b1;
			end
			// wait for start to drop once done is up
			DONE: if (o_done && !i_start) begin
				state_nxt = IDLE;
			end
			default: state_nxt = IDLE;
		endcase
	end

	// --------------------------------------------------
	// state, fcs strobe, done acknowledge
	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			o_state  <= IDLE;
			o_fcs_go <= 1'b0;
			fcs_wr   <= 1'b0;
			o_done   <= 1'b0;
		end else begin
			o_state <= state_nxt;
			// last data beat is in flight during FCS, crc ready next cycle
			o_fcs_go <= (o_state == FCS);
			fcs_wr   <= o_fcs_go;
			if (o_state == DONE && o_done && !i_start) begin
				o_done <= 1'b0;
			end else if (o_state == DONE && fcs_wr) begin
				o_done <= 1'b1;
			end
		end
	end

endmodule

// ==== design/pktgen_fcs.sv ====
/* crc-32 append and frame memory writer */
module pktgen_fcs
	import pktgen_pkg::*;
	(
	input  logic       clk,
	input  logic       i_rst_n,
	pktgen_if.sink     snk,
	input  logic       i_fcs_go,
	input  gen_state_t i_state,
	output logic       o_mem_wr,
	output addr_t      o_mem_addr,
	output word_t      o_mem_data,
	output logic       o_mem_sop,
	output logic       o_mem_eop,
	output addr_t      o_last_addr
);

	word_t crc;
	word_t crc_nxt;
	word_t fcs_word;
	addr_t next_addr;
	logic  wr_en;

	// --------------------------------------------------
	// one 32-bit word into a reflected crc
	// bytes go least significant first, bits lsb first
	function automatic word_t crc32_word(input word_t crc_in, input word_t d);
		word_t c;
		c = crc_in;
		for (int i = 0; i < 32; i++) begin
			if (c[0] ^ d[i]) begin
				c = (c >> 1) ^ CRC_POLY;
			end else begin
				c = c >> 1;
			end
		end
		return c;
	endfunction

	// sop restarts the accumulation
	assign crc_nxt = crc32_word(snk.sop ? CRC_INIT : crc, snk.data);

	always_ff @(posedge clk) begin
		if (snk.vld) begin
			crc <= crc_nxt;
		end
		// final value, inverted, held for the fcs cycle
		if (snk.vld && snk.last) begin
			fcs_word <= ~crc_nxt;
		end
	end

	// --------------------------------------------------
	// memory write, data beat or fcs word
	assign wr_en = snk.vld | i_fcs_go;

	always_ff @(posedge clk) begin
		if (wr_en) begin
			o_mem_addr <= next_addr;
			o_mem_data <= i_fcs_go ? fcs_word : snk.data;
		end
	end

	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			o_mem_wr    <= 1'b0;
			o_mem_sop   <= 1'b0;
			o_mem_eop   <= 1'b0;
			next_addr   <= '0;
			o_last_addr <= '0;
		end else begin
			o_mem_wr  <= wr_en;
			o_mem_sop <= snk.vld & snk.sop;
			o_mem_eop <= i_fcs_go;
			// each run starts at address zero
			if (i_state == IDLE) begin
				next_addr <= '0;
			end else if (wr_en) begin
				next_addr <= next_addr + addr_t'(1);
			end
			// next free address after every fcs word
			if (i_fcs_go) begin
				o_last_addr <= next_addr + addr_t'(1);
			end
		end
	end

endmodule

// ==== design/pktgen_if.sv ====
/* frame word stream */
interface pktgen_if
	import pktgen_pkg::*;
	();

	// one word per beat, no back-pressure
	logic  vld;
	logic  sop;
	logic  last;
	word_t data;

	// payload source side
	modport source (output vld, output sop, output last, output data);

	// crc and memory writer side
	modport sink (input vld, input sop, input last, input data);

endinterface

// ==== design/pktgen_pattern.sv ====
/* frame length and payload source */
module pktgen_pattern
	import pktgen_pkg::*;
	#(
	parameter int MAX_LEN = 500
	) (
	input  logic       clk,
	input  logic       i_rst_n,
	input  logic       i_frame_go,
	input  gen_state_t i_state,
	input  len_t       i_word_idx,
	input  len_mode_t  i_len_mode,
	input  pat_mode_t  i_pat_mode,
	input  len_t       i_base_len,
	input  len_t       i_len_step,
	input  logic [7:0] i_fix_byte,
	output len_t       o_frame_len,
	pktgen_if.source   src
);

	localparam logic [11:0] LEN_LIMIT = 12'(MAX_LEN);

	logic [11:0] len_sum;
	word_t       lfsr;
	word_t       lfsr_nxt;
	word_t       word_nxt;

	// --------------------------------------------------
	// frame length
	assign len_sum = {1'b0, o_frame_len} + {1'b0, i_len_step};

	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			o_frame_len <= '0;
		end else if (i_frame_go && i_state == IDLE) begin
			o_frame_len <= i_base_len;
		end else if (i_frame_go && i_len_mode == LEN_INC) begin
			// grow per frame, clamp at the limit
			o_frame_len <= (len_sum > LEN_LIMIT) ? len_t'(MAX_LEN) : len_sum[10:0];
		end
	end

	// --------------------------------------------------
	// payload
	assign lfsr_nxt = lfsr[0] ? ((lfsr >> 1) ^ LFSR_POLY) : (lfsr >> 1);

	always_comb begin
		case (i_pat_mode)
			PAT_INC:  word_nxt = word_t'(i_word_idx);
			PAT_LFSR: word_nxt = lfsr_nxt;
			// fixed byte, also for the unused code
			default:  word_nxt = {4{i_fix_byte}};
		endcase
	end

	// lfsr restarts with every run, steps once per data word
	always_ff @(posedge clk) begin
		if (i_frame_go && i_state == IDLE) begin
			lfsr <= LFSR_SEED;
		end else if (i_state == FRAME) begin
			lfsr <= lfsr_nxt;
		end
		if (i_state == FRAME) begin
			src.data <= word_nxt;
		end
	end

	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			src.vld  <= 1'b0;
			src.sop  <= 1'b0;
			src.last <= 1'b0;
		end else begin
			src.vld  <= (i_state == FRAME);
			src.sop  <= (i_state == FRAME) && (i_word_idx == '0);
			src.last <= (i_state == FRAME) && (i_word_idx == o_frame_len - len_t'(1));
		end
	end

endmodule

// ==== design/pktgen_pkg.sv ====
/* frame generator shared types */
package pktgen_pkg;

	// data path widths
	typedef logic [31:0] word_t;
	typedef logic [10:0] len_t;
	typedef logic [12:0] addr_t;
	typedef logic [12:0] cnt_t;

	// mode selects
	typedef logic        len_mode_t;
	typedef logic [1:0]  pat_mode_t;

	localparam len_mode_t LEN_INC  = 1'b1;
	localparam pat_mode_t PAT_INC  = 2'd1;
	localparam pat_mode_t PAT_LFSR = 2'd2;

	// generator state machine
	typedef enum logic [2:0] {
		IDLE,
		FRAME,
		FCS,
		GAP,
		DONE
	} gen_state_t;

	// ethernet crc-32, reflected form
	localparam word_t CRC_POLY = 32'hEDB8_8320;
	localparam word_t CRC_INIT = 32'hFFFF_FFFF;

	// payload lfsr, galois form, taps 32 22 2 1
	localparam word_t LFSR_POLY = 32'h8020_0003;
	localparam word_t LFSR_SEED = 32'hACE1_2469;

endpackage

// ==== design/pktgen_timer.sv ====
/* frame and gap counters */
module pktgen_timer
	import pktgen_pkg::*;
	#(
	parameter int GAP_CYCLES = 16
	) (
	input  logic       clk,
	input  logic       i_rst_n,
	input  gen_state_t i_state,
	input  len_t       i_frame_len,
	input  cnt_t       i_num_frames,
	output len_t       o_word_idx,
	output logic       o_last_word,
	output logic       o_gap_done,
	output logic       o_all_sent
);

	// wide enough even for a zero gap
	localparam int GW = $clog2(GAP_CYCLES + 2);

	logic [GW-1:0] gap_cnt;
	cnt_t          frame_cnt;

	// last word of the frame, length excludes fcs
	assign o_last_word = (i_state == FRAME) && (o_word_idx == i_frame_len - len_t'(1));
	// gap state lasts exactly GAP_CYCLES cycles
	assign o_gap_done  = (i_state == GAP) && (gap_cnt == GW'(GAP_CYCLES - 1));
	// checked in FCS, count already includes the current frame
	assign o_all_sent  = (frame_cnt >= i_num_frames);

	always_ff @(posedge clk) begin
		if (!i_rst_n || i_state == IDLE) begin
			o_word_idx <= '0;
			gap_cnt    <= '0;
			frame_cnt  <= '0;
		end else begin
			// word index within the frame
			if (i_state == FRAME && !o_last_word) begin
				o_word_idx <= o_word_idx + len_t'(1);
			end else begin
				o_word_idx <= '0;
			end
			// idle cycles between frames
			if (i_state == GAP) begin
				gap_cnt <= gap_cnt + GW'(1);
			end else begin
				gap_cnt <= '0;
			end
			// finished frames
			if (o_last_word) begin
				frame_cnt <= frame_cnt + cnt_t'(1);
			end
		end
	end

endmodule

// ==== design/pktgen_top.sv ====
/* frame generator top */
module pktgen_top
	import pktgen_pkg::*;
	#(
	parameter int GAP_CYCLES = 16,
	parameter int MAX_LEN    = 500
	) (
	input  logic       clk,
	input  logic       i_rst_n,
	input  logic       i_start,
	input  len_mode_t  i_len_mode,
	input  pat_mode_t  i_pat_mode,
	input  len_t       i_base_len,
	input  len_t       i_len_step,
	input  logic [7:0] i_fix_byte,
	input  cnt_t       i_num_frames,
	output logic       o_done,
	output logic       o_mem_wr,
	output addr_t      o_mem_addr,
	output word_t      o_mem_data,
	output logic       o_mem_sop,
	output logic       o_mem_eop,
	output addr_t      o_last_addr
);

	gen_state_t state;
	logic       frame_go;
	logic       fcs_go;
	logic       last_word;
	logic       gap_done;
	logic       all_sent;
	len_t       word_idx;
	len_t       frame_len;

	// payload to crc and memory writer
	pktgen_if u_word_if ();

	pktgen_ctrl #(
		.GAP_CYCLES (GAP_CYCLES)
	) u_ctrl (
		.clk         (clk),
		.i_rst_n     (i_rst_n),
		.i_start     (i_start),
		.i_last_word (last_word),
		.i_gap_done  (gap_done),
		.i_all_sent  (all_sent),
		.o_state     (state),
		.o_frame_go  (frame_go),
		.o_fcs_go    (fcs_go),
		.o_done      (o_done)
	);

	pktgen_timer #(
		.GAP_CYCLES (GAP_CYCLES)
	) u_timer (
		.clk          (clk),
		.i_rst_n      (i_rst_n),
		.i_state      (state),
		.i_frame_len  (frame_len),
		.i_num_frames (i_num_frames),
		.o_word_idx   (word_idx),
		.o_last_word  (last_word),
		.o_gap_done   (gap_done),
		.o_all_sent   (all_sent)
	);

	pktgen_pattern #(
		.MAX_LEN (MAX_LEN)
	) u_pattern (
		.clk         (clk),
		.i_rst_n     (i_rst_n),
		.i_frame_go  (frame_go),
		.i_state     (state),
		.i_word_idx  (word_idx),
		.i_len_mode  (i_len_mode),
		.i_pat_mode  (i_pat_mode),
		.i_base_len  (i_base_len),
		.i_len_step  (i_len_step),
		.i_fix_byte  (i_fix_byte),
		.o_frame_len (frame_len),
		.src         (u_word_if)
	);

	pktgen_fcs u_fcs (
		.clk         (clk),
		.i_rst_n     (i_rst_n),
		.snk         (u_word_if),
		.i_fcs_go    (fcs_go),
		.i_state     (state),
		.o_mem_wr    (o_mem_wr),
		.o_mem_addr  (o_mem_addr),
		.o_mem_data  (o_mem_data),
		.o_mem_sop   (o_mem_sop),
		.o_mem_eop   (o_mem_eop),
		.o_last_addr (o_last_addr)
	);

endmodule

// ==== pktgen.f ====
design/pktgen_pkg.sv
design/pktgen_if.sv
design/pktgen_ctrl.sv
design/pktgen_timer.sv
design/pktgen_pattern.sv
design/pktgen_fcs.sv
design/pktgen_top.sv
bench/pktgen_sva.sv
bench/pktgen_tb.sv
